/* verilog/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath and bus width
`define DATA_WIDTH 32

// general register file
`define REG_COUNT 16
`define REG_ADDR_WIDTH 4

// instruction fields
`define OPCODE_WIDTH 5
`define IMM_WIDTH 19

// product spans two registers
`define PROD_WIDTH (2 * `DATA_WIDTH)

`endif

/* verilog/isaPkg.sv */
`include "cpu_consts.svh"

package isaPkg;

    typedef enum logic [`OPCODE_WIDTH-1:0] {
        opLdi  = 5'd0,
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opAnd  = 5'd5,
        opOr   = 5'd6,
        opMul  = 5'd15,  // same encoding as the reference mul
        opMfhi = 5'd16,
        opMflo = 5'd17
    } opcodeT;

    // instruction word layout
    parameter int opcodeHi = 31;
    parameter int opcodeLo = opcodeHi - `OPCODE_WIDTH + 1;
    parameter int raHi = 26;
    parameter int raLo = raHi - `REG_ADDR_WIDTH + 1;
    parameter int rbHi = 22;
    parameter int rbLo = rbHi - `REG_ADDR_WIDTH + 1;
    parameter int rcHi = 18;
    parameter int rcLo = rcHi - `REG_ADDR_WIDTH + 1;
    parameter int immHi = `IMM_WIDTH - 1;  // overlaps rc
    parameter int immLo = 0;

endpackage

/* verilog/ctrlPkg.sv */
package ctrlPkg;

    // sequencer steps, one bus transfer per step
    typedef enum logic [2:0] {
        stIdle    = 3'd0,
        stDecode  = 3'd1,
        stReadA   = 3'd2,
        stCompute = 3'd3,
        stWriteLo = 3'd4,
        stWriteHi = 3'd5,
        stMove    = 3'd6
    } stepT;

    // who owns the internal bus
    typedef enum logic [2:0] {
        srcNone  = 3'd0,
        srcMdr   = 3'd1,
        srcReg   = 3'd2,
        srcZLow  = 3'd3,
        srcZHigh = 3'd4,
        srcHi    = 3'd5,
        srcLo    = 3'd6,
        srcImm   = 3'd7
    } busSrcT;

endpackage

/* verilog/registerFile.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module registerFile (
    input  logic                       Clock,
    input  logic                       rst,
    input  logic [`DATA_WIDTH-1:0]     busData,
    input  logic [`REG_ADDR_WIDTH-1:0] regReadAddr,
    input  logic [`REG_ADDR_WIDTH-1:0] regWriteAddr,
    input  logic                       regWriteEn,
    input  logic                       hiWriteEn,
    input  logic                       loWriteEn,
    output logic [`DATA_WIDTH-1:0]     regReadData,
    output logic [`DATA_WIDTH-1:0]     hiData,
    output logic [`DATA_WIDTH-1:0]     loData
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
    logic [`DATA_WIDTH-1:0] hiReg;
    logic [`DATA_WIDTH-1:0] loReg;

    // general registers, single write port fed from the bus
    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (regWriteEn) begin
            regs[regWriteAddr] <= busData;
        end
    end

    // product halves
    always_ff @(posedge Clock) begin
        if (rst) begin
            hiReg <= '0;
            loReg <= '0;
        end else begin
            if (hiWriteEn) begin
                hiReg <= busData;
            end
            if (loWriteEn) begin
                loReg <= busData;
            end
        end
    end

    assign regReadData = regs[regReadAddr];  // combinational read
    assign hiData      = hiReg;
    assign loData      = loReg;

    // the bus carries one value per step, so only one destination may take it
    writeEnOneHot: assert property (
        @(posedge Clock) disable iff (rst)
        $onehot0({regWriteEn, hiWriteEn, loWriteEn})
    ) else $error("more than one register write enable in a cycle");

endmodule

/* verilog/aluUnit.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module aluUnit (
    input  logic                   Clock,
    input  logic                   rst,
    input  logic [`DATA_WIDTH-1:0] busData,
    input  logic                   yEnable,
    input  logic                   zEnable,
    input  isaPkg::opcodeT         aluOp,
    output logic [`DATA_WIDTH-1:0] zLow,
    output logic [`DATA_WIDTH-1:0] zHigh
);

    logic [`DATA_WIDTH-1:0] yReg;
    logic [`PROD_WIDTH-1:0] zReg;
    logic [`PROD_WIDTH-1:0] result;
    logic signed [`PROD_WIDTH-1:0] product;

    // Y holds the first operand, the bus supplies the second one
    always_ff @(posedge Clock) begin
        if (rst) begin
            yReg <= '0;
        end else if (yEnable) begin
            yReg <= busData;
        end
    end

    assign product = $signed(yReg) * $signed(busData);  // full 64-bit signed product

    always_comb begin
        result = '0;
        case (aluOp)
            isaPkg::opAdd: result[`DATA_WIDTH-1:0] = yReg + busData;
            isaPkg::opSub: result[`DATA_WIDTH-1:0] = yReg - busData;
            isaPkg::opAnd: result[`DATA_WIDTH-1:0] = yReg & busData;
            isaPkg::opOr:  result[`DATA_WIDTH-1:0] = yReg | busData;
            isaPkg::opMul: result = product;
            default:       result = '0;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            zReg <= '0;
        end else if (zEnable) begin
            zReg <= result;
        end
    end

    assign zLow  = zReg[`DATA_WIDTH-1:0];
    assign zHigh = zReg[`PROD_WIDTH-1:`DATA_WIDTH];

    // the sequencer only enters its compute step for ALU instructions
    zOnlyForAluOps: assert property (
        @(posedge Clock) disable iff (rst)
        zEnable |-> aluOp inside {isaPkg::opAdd, isaPkg::opSub, isaPkg::opAnd,
                                  isaPkg::opOr, isaPkg::opMul}
    ) else $error("Z loaded with a non-ALU opcode");

endmodule

/* verilog/controlSequencer.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module controlSequencer (
    input  logic                       Clock,
    input  logic                       rst,
    input  logic                       instrValid,
    input  logic [`DATA_WIDTH-1:0]     instrWord,
    output logic                       instrReady,
    input  logic [`DATA_WIDTH-1:0]     regReadData,
    input  logic [`DATA_WIDTH-1:0]     hiData,
    input  logic [`DATA_WIDTH-1:0]     loData,
    input  logic [`DATA_WIDTH-1:0]     zLow,
    input  logic [`DATA_WIDTH-1:0]     zHigh,
    output logic [`DATA_WIDTH-1:0]     busData,
    output logic [`REG_ADDR_WIDTH-1:0] regReadAddr,
    output logic [`REG_ADDR_WIDTH-1:0] regWriteAddr,
    output logic                       regWriteEn,
    output logic                       hiWriteEn,
    output logic                       loWriteEn,
    output logic                       yEnable,
    output logic                       zEnable,
    output isaPkg::opcodeT             aluOp,
    output logic                       retireValid,
    output logic [`REG_ADDR_WIDTH-1:0] retireDest,
    output logic [`DATA_WIDTH-1:0]     retireData
);

    logic [`DATA_WIDTH-1:0]     mdr;
    logic [`DATA_WIDTH-1:0]     ir;
    ctrlPkg::stepT              step;
    ctrlPkg::stepT              nextStep;
    ctrlPkg::busSrcT            busSrc;
    isaPkg::opcodeT             mdrOp;
    isaPkg::opcodeT             irOp;
    logic [`REG_ADDR_WIDTH-1:0] raField;
    logic [`REG_ADDR_WIDTH-1:0] rbField;
    logic [`REG_ADDR_WIDTH-1:0] rcField;
    logic [`DATA_WIDTH-1:0]     immExt;
    logic                       accept;
    logic                       lastStep;

    assign mdrOp   = isaPkg::opcodeT'(mdr[isaPkg::opcodeHi:isaPkg::opcodeLo]);
    assign irOp    = isaPkg::opcodeT'(ir[isaPkg::opcodeHi:isaPkg::opcodeLo]);
    assign raField = ir[isaPkg::raHi:isaPkg::raLo];
    assign rbField = ir[isaPkg::rbHi:isaPkg::rbLo];
    assign rcField = ir[isaPkg::rcHi:isaPkg::rcLo];
    assign immExt  = {{(`DATA_WIDTH-`IMM_WIDTH){ir[isaPkg::immHi]}},
                      ir[isaPkg::immHi:isaPkg::immLo]};  // sign extend

    assign instrReady = (step == ctrlPkg::stIdle);
    assign accept     = instrValid && instrReady;

    // MDR takes the incoming word, IR is loaded from the bus while decoding
    always_ff @(posedge Clock) begin
        if (accept) begin
            mdr <= instrWord;
        end
        if (step == ctrlPkg::stDecode) begin
            ir <= busData;
        end
    end

    always_comb begin
        nextStep = step;
        case (step)
            ctrlPkg::stIdle: begin
                if (instrValid) begin
                    nextStep = ctrlPkg::stDecode;
                end
            end
            ctrlPkg::stDecode: begin
                case (mdrOp)  // IR is not loaded yet, decode from MDR
                    isaPkg::opLdi, isaPkg::opMfhi, isaPkg::opMflo:
                        nextStep = ctrlPkg::stMove;
                    isaPkg::opAdd, isaPkg::opSub, isaPkg::opAnd, isaPkg::opOr,
                    isaPkg::opMul:
                        nextStep = ctrlPkg::stReadA;
                    default:
                        nextStep = ctrlPkg::stIdle;
                endcase
            end
            ctrlPkg::stReadA:   nextStep = ctrlPkg::stCompute;
            ctrlPkg::stCompute: nextStep = ctrlPkg::stWriteLo;
            ctrlPkg::stWriteLo: begin
                nextStep = (irOp == isaPkg::opMul) ? ctrlPkg::stWriteHi : ctrlPkg::stIdle;
            end
            ctrlPkg::stWriteHi: nextStep = ctrlPkg::stIdle;
            ctrlPkg::stMove:    nextStep = ctrlPkg::stIdle;
            default:            nextStep = ctrlPkg::stIdle;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            step <= ctrlPkg::stIdle;
        end else begin
            step <= nextStep;
        end
    end

    // one bus owner per step
    always_comb begin
        busSrc = ctrlPkg::srcNone;
        case (step)
            ctrlPkg::stDecode:  busSrc = ctrlPkg::srcMdr;
            ctrlPkg::stReadA:   busSrc = ctrlPkg::srcReg;
            ctrlPkg::stCompute: busSrc = ctrlPkg::srcReg;
            ctrlPkg::stWriteLo: busSrc = ctrlPkg::srcZLow;
            ctrlPkg::stWriteHi: busSrc = ctrlPkg::srcZHigh;
            ctrlPkg::stMove: begin
                case (irOp)
                    isaPkg::opMfhi: busSrc = ctrlPkg::srcHi;
                    isaPkg::opMflo: busSrc = ctrlPkg::srcLo;
                    default:        busSrc = ctrlPkg::srcImm;
                endcase
            end
            default: busSrc = ctrlPkg::srcNone;
        endcase
    end

    always_comb begin
        case (busSrc)
            ctrlPkg::srcMdr:   busData = mdr;
            ctrlPkg::srcReg:   busData = regReadData;
            ctrlPkg::srcZLow:  busData = zLow;
            ctrlPkg::srcZHigh: busData = zHigh;
            ctrlPkg::srcHi:    busData = hiData;
            ctrlPkg::srcLo:    busData = loData;
            ctrlPkg::srcImm:   busData = immExt;
            default:           busData = '0;
        endcase
    end

    assign regReadAddr  = (step == ctrlPkg::stCompute) ? rbField : raField;  // ra first, then rb
    assign regWriteAddr = rcField;
    assign yEnable      = (step == ctrlPkg::stReadA);
    assign zEnable      = (step == ctrlPkg::stCompute);
    assign aluOp        = irOp;

    assign regWriteEn = (step == ctrlPkg::stMove) ||
                        (step == ctrlPkg::stWriteLo && irOp != isaPkg::opMul);
    assign loWriteEn  = (step == ctrlPkg::stWriteLo) && (irOp == isaPkg::opMul);
    assign hiWriteEn  = (step == ctrlPkg::stWriteHi);

    // the final write of each instruction
    assign lastStep = regWriteEn || hiWriteEn;

    always_ff @(posedge Clock) begin
        if (rst) begin
            retireValid <= 1'b0;
        end else begin
            retireValid <= lastStep;
        end
    end

    always_ff @(posedge Clock) begin
        if (lastStep) begin
            retireDest <= rcField;
            retireData <= hiWriteEn ? zLow : busData;  // mul reports the low half
        end
    end

    stepInRange: assert property (
        @(posedge Clock) disable iff (rst)
        step inside {ctrlPkg::stIdle, ctrlPkg::stDecode, ctrlPkg::stReadA,
                     ctrlPkg::stCompute, ctrlPkg::stWriteLo, ctrlPkg::stWriteHi,
                     ctrlPkg::stMove}
    ) else $error("sequencer step outside its encoding");

    retireSingleCycle: assert property (
        @(posedge Clock) disable iff (rst)
        retireValid |=> !retireValid
    ) else $error("retireValid high for two cycles");

    // an accepted word takes the sequencer out of idle
    readyDropsOnAccept: assert property (
        @(posedge Clock) disable iff (rst)
        accept |=> !instrReady
    ) else $error("instrReady still high after an accepted word");

endmodule

/* verilog/busCpu.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module busCpu (
    input  logic                       Clock,
    input  logic                       rst,
    input  logic                       instrValid,
    input  logic [`DATA_WIDTH-1:0]     instrWord,
    output logic                       instrReady,
    output logic                       retireValid,
    output logic [`REG_ADDR_WIDTH-1:0] retireDest,
    output logic [`DATA_WIDTH-1:0]     retireData
);

    logic [`DATA_WIDTH-1:0]     busData;
    logic [`REG_ADDR_WIDTH-1:0] regReadAddr;
    logic [`REG_ADDR_WIDTH-1:0] regWriteAddr;
    logic                       regWriteEn;
    logic                       hiWriteEn;
    logic                       loWriteEn;
    logic                       yEnable;
    logic                       zEnable;
    isaPkg::opcodeT             aluOp;
    logic [`DATA_WIDTH-1:0]     regReadData;
    logic [`DATA_WIDTH-1:0]     hiData;
    logic [`DATA_WIDTH-1:0]     loData;
    logic [`DATA_WIDTH-1:0]     zLow;
    logic [`DATA_WIDTH-1:0]     zHigh;

    controlSequencer controlSequencer_i (
        .Clock        (Clock),
        .rst          (rst),
        .instrValid   (instrValid),
        .instrWord    (instrWord),
        .instrReady   (instrReady),
        .regReadData  (regReadData),
        .hiData       (hiData),
        .loData       (loData),
        .zLow         (zLow),
        .zHigh        (zHigh),
        .busData      (busData),
        .regReadAddr  (regReadAddr),
        .regWriteAddr (regWriteAddr),
        .regWriteEn   (regWriteEn),
        .hiWriteEn    (hiWriteEn),
        .loWriteEn    (loWriteEn),
        .yEnable      (yEnable),
        .zEnable      (zEnable),
        .aluOp        (aluOp),
        .retireValid  (retireValid),
        .retireDest   (retireDest),
        .retireData   (retireData)
    );

    registerFile registerFile_i (
        .Clock        (Clock),
        .rst          (rst),
        .busData      (busData),
        .regReadAddr  (regReadAddr),
        .regWriteAddr (regWriteAddr),
        .regWriteEn   (regWriteEn),
        .hiWriteEn    (hiWriteEn),
        .loWriteEn    (loWriteEn),
        .regReadData  (regReadData),
        .hiData       (hiData),
        .loData       (loData)
    );

    aluUnit aluUnit_i (
        .Clock   (Clock),
        .rst     (rst),
        .busData (busData),
        .yEnable (yEnable),
        .zEnable (zEnable),
        .aluOp   (aluOp),
        .zLow    (zLow),
        .zHigh   (zHigh)
    );

endmodule

/* tests/busCpuTb.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module busCpuTb;

    localparam int totalInstrs   = 300;
    localparam int timeoutCycles = 2000;  // 300 instructions at up to 6 cycles, plus reset

    logic                       Clock = 1'b0;
    logic                       rst;
    logic                       instrValid;
    logic [`DATA_WIDTH-1:0]     instrWord;
    logic                       instrReady;
    logic                       retireValid;
    logic [`REG_ADDR_WIDTH-1:0] retireDest;
    logic [`DATA_WIDTH-1:0]     retireData;

    // reference model state
    logic [`DATA_WIDTH-1:0]     modelRegs [`REG_COUNT];
    logic [`DATA_WIDTH-1:0]     modelHi;
    logic [`DATA_WIDTH-1:0]     modelLo;

    // expectation for the instruction in flight
    isaPkg::opcodeT             expOp;
    logic [`REG_ADDR_WIDTH-1:0] expDest;
    logic [`DATA_WIDTH-1:0]     expData;
    int                         expCycles;
    int                         waitCycles;
    logic                       outstanding;
    logic                       everAccepted;

    logic [15:0] lfsrState = 16'd51340;
    int          cycleCount = 0;
    int          issued = 0;

    busCpu busCpu_i (
        .Clock       (Clock),
        .rst         (rst),
        .instrValid  (instrValid),
        .instrWord   (instrWord),
        .instrReady  (instrReady),
        .retireValid (retireValid),
        .retireDest  (retireDest),
        .retireData  (retireData)
    );

    always #5 Clock = ~Clock;

    // x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback  = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], feedback};
            value     = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic logic [31:0] encodeRegOp(input isaPkg::opcodeT op, input logic [3:0] ra,
                                                input logic [3:0] rb, input logic [3:0] rc);
        return {op, ra, rb, rc, 15'd0};
    endfunction

    function automatic logic [31:0] encodeLdi(input logic [18:0] imm);
        return {isaPkg::opLdi, 8'd0, imm};  // rc is the top of the immediate
    endfunction

    function automatic isaPkg::opcodeT pickOpcode(input logic [2:0] sel);
        case (sel)
            3'd0:    return isaPkg::opLdi;
            3'd1:    return isaPkg::opAdd;
            3'd2:    return isaPkg::opSub;
            3'd3:    return isaPkg::opAnd;
            3'd4:    return isaPkg::opOr;
            3'd5:    return isaPkg::opMul;
            3'd6:    return isaPkg::opMfhi;
            default: return isaPkg::opMflo;
        endcase
    endfunction

    task automatic failCheck(input string msg);
        $display("error at %0t: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "check failed");
    endtask

    // apply one accepted word to the model and record what must retire
    task automatic modelStep(input logic [31:0] word);
        isaPkg::opcodeT     op;
        logic [3:0]         ra;
        logic [3:0]         rb;
        logic [3:0]         rc;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        value;
        logic signed [63:0] prod;
        int                 cycles;
        op     = isaPkg::opcodeT'(word[31:27]);
        ra     = word[26:23];
        rb     = word[22:19];
        rc     = word[18:15];
        a      = modelRegs[ra];
        b      = modelRegs[rb];
        value  = '0;
        cycles = 0;
        case (op)
            isaPkg::opLdi: begin
                value = {{(`DATA_WIDTH-`IMM_WIDTH){word[`IMM_WIDTH-1]}}, word[`IMM_WIDTH-1:0]};
                cycles = 2;
            end
            isaPkg::opAdd: begin
                value = a + b;
                cycles = 4;
            end
            isaPkg::opSub: begin
                value = a - b;
                cycles = 4;
            end
            isaPkg::opAnd: begin
                value = a & b;
                cycles = 4;
            end
            isaPkg::opOr: begin
                value = a | b;
                cycles = 4;
            end
            isaPkg::opMul: begin
                prod    = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                modelLo = prod[31:0];
                modelHi = prod[63:32];
                value   = prod[31:0];  // retire shows the low half
                cycles  = 5;
            end
            isaPkg::opMfhi: begin
                value = modelHi;
                cycles = 2;
            end
            isaPkg::opMflo: begin
                value = modelLo;
                cycles = 2;
            end
            default: cycles = 0;
        endcase
        if (op != isaPkg::opMul) begin
            modelRegs[rc] = value;
        end
        expOp     <= op;
        expDest   <= rc;
        expData   <= value;
        expCycles <= cycles;
    endtask

    always @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                modelRegs[i] = '0;
            end
            modelHi      = '0;
            modelLo      = '0;
            outstanding  <= 1'b0;
            everAccepted <= 1'b0;
            waitCycles   <= 0;
            expOp        <= isaPkg::opLdi;
            expDest      <= '0;
            expData      <= '0;
            expCycles    <= 0;
        end else begin
            if (retireValid) begin
                outstanding <= 1'b0;
            end
            if (instrValid && instrReady) begin  // accept wins over a retire in the same cycle
                modelStep(instrWord);
                outstanding  <= 1'b1;
                everAccepted <= 1'b1;
                waitCycles   <= 0;
            end else if (outstanding) begin
                waitCycles <= waitCycles + 1;
            end
        end
    end

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == timeoutCycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeoutCycles);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    resetIdle: assert property (@(posedge Clock) disable iff (rst)
        !everAccepted |-> instrReady && !retireValid)
        else failCheck("core not idle and ready after reset");

    retireHasOwner: assert property (@(posedge Clock) disable iff (rst)
        retireValid |-> outstanding)
        else failCheck("retire without an accepted instruction");

    busyNotReady: assert property (@(posedge Clock) disable iff (rst)
        outstanding && !retireValid |-> !instrReady)
        else failCheck("instrReady high while an instruction is in flight");

    retireInTime: assert property (@(posedge Clock) disable iff (rst)
        outstanding && !retireValid |-> waitCycles < 6)
        else failCheck("accepted instruction never retired");

    retireLatency: assert property (@(posedge Clock) disable iff (rst)
        retireValid |-> waitCycles == expCycles)
        else failCheck($sformatf("retire after %0d cycles, expected %0d",
                                 $sampled(waitCycles), $sampled(expCycles)));

    ldiResult: assert property (@(posedge Clock) disable iff (rst)
        retireValid && expOp == isaPkg::opLdi |-> retireDest == expDest && retireData == expData)
        else failCheck($sformatf("ldi retired R%0d = %h, expected R%0d = %h",
                                 $sampled(retireDest), $sampled(retireData),
                                 $sampled(expDest), $sampled(expData)));

    aluResult: assert property (@(posedge Clock) disable iff (rst)
        retireValid && expOp inside {isaPkg::opAdd, isaPkg::opSub, isaPkg::opAnd, isaPkg::opOr}
        |-> retireDest == expDest && retireData == expData)
        else failCheck($sformatf("ALU op retired R%0d = %h, expected R%0d = %h",
                                 $sampled(retireDest), $sampled(retireData),
                                 $sampled(expDest), $sampled(expData)));

    mulResult: assert property (@(posedge Clock) disable iff (rst)
        retireValid && expOp == isaPkg::opMul |-> retireDest == expDest && retireData == expData)
        else failCheck($sformatf("mul retired rc %0d low %h, expected rc %0d low %h",
                                 $sampled(retireDest), $sampled(retireData),
                                 $sampled(expDest), $sampled(expData)));

    moveResult: assert property (@(posedge Clock) disable iff (rst)
        retireValid && expOp inside {isaPkg::opMfhi, isaPkg::opMflo}
        |-> retireDest == expDest && retireData == expData)
        else failCheck($sformatf("move retired R%0d = %h, expected R%0d = %h",
                                 $sampled(retireDest), $sampled(retireData),
                                 $sampled(expDest), $sampled(expData)));

    // called just after a falling edge, returns just after the accepting edge
    task automatic issueWord(input logic [31:0] word, input int gap);
        for (int i = 0; i < gap; i++) begin
            instrValid = 1'b0;
            @(negedge Clock);
        end
        instrValid = 1'b1;
        instrWord  = word;
        while (!instrReady) begin  // word held stable under back-pressure
            @(negedge Clock);
        end
        @(negedge Clock);
        instrValid = 1'b0;
        issued++;
    endtask

    task automatic issueRandom();
        logic [31:0]    r;
        isaPkg::opcodeT op;
        int             gap;
        r   = takeBits(2);
        gap = {30'd0, r[1:0]};
        r   = takeBits(3);
        op  = pickOpcode(r[2:0]);
        if (op == isaPkg::opLdi) begin
            r = takeBits(19);
            issueWord(encodeLdi(r[18:0]), gap);
        end else begin
            r = takeBits(12);
            issueWord(encodeRegOp(op, r[11:8], r[7:4], r[3:0]), gap);
            if (op == isaPkg::opMul) begin
                r = takeBits(8);
                issueWord(encodeRegOp(isaPkg::opMflo, 4'd0, 4'd0, r[7:4]), 0);
                issueWord(encodeRegOp(isaPkg::opMfhi, 4'd0, 4'd0, r[3:0]), 0);
            end
        end
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        rst        = 1'b1;
        instrValid = 1'b0;
        instrWord  = '0;
        repeat (16) @(posedge Clock);
        @(negedge Clock);
        rst = 1'b0;
        repeat (3) @(negedge Clock);  // idle a little so the reset state is seen

        // reference sequence, R6 = R7 = 2 through R0 and the still-zero R1
        issueWord(encodeLdi(19'd2), 0);
        issueWord(encodeRegOp(isaPkg::opOr, 4'd0, 4'd1, 4'd6), 0);
        issueWord(encodeRegOp(isaPkg::opOr, 4'd0, 4'd1, 4'd7), 1);
        issueWord(32'h7B38_0000, 0);  // mul R6, R7
        issueWord(encodeRegOp(isaPkg::opMflo, 4'd0, 4'd0, 4'd1), 0);
        issueWord(encodeRegOp(isaPkg::opMfhi, 4'd0, 4'd0, 4'd2), 2);

        // negative immediates and a signed product with a nonzero high half
        issueWord(encodeLdi(19'h7FFFF), 0);
        issueWord(encodeLdi(19'h40000), 3);
        issueWord(encodeRegOp(isaPkg::opSub, 4'd0, 4'd15, 4'd3), 0);
        issueWord(encodeRegOp(isaPkg::opMul, 4'd8, 4'd6, 4'd5), 0);
        issueWord(encodeRegOp(isaPkg::opMfhi, 4'd0, 4'd0, 4'd9), 0);
        issueWord(encodeRegOp(isaPkg::opMflo, 4'd0, 4'd0, 4'd10), 0);

        while (issued < totalInstrs) begin
            issueRandom();
        end

        while (outstanding) begin
            @(negedge Clock);
        end
        @(negedge Clock);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* compile.f */
+incdir+verilog
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/registerFile.sv
verilog/aluUnit.sv
verilog/controlSequencer.sv
verilog/busCpu.sv
tests/busCpuTb.sv

/* Makefile */
# Verilator build and run for the bus CPU testbench

VERILATOR ?= verilator
TOP       ?= busCpuTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert -Wall
SIM_FLAGS ?=
PASS_MSG  ?= Simulation PASSED

SOURCES := $(wildcard verilog/*.sv verilog/*.svh tests/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
